//--- list.f
+incdir+tb
hdl/legv8_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/legv8_core.sv
tb/tb_legv8_core.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f list.f --top-module tb_legv8_core -Mdir obj_dir
	./obj_dir/Vtb_legv8_core | tee $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/tb_programs.svh
localparam int NUM_PROGS  = 5;
localparam int MAX_INSTR  = 16;
localparam int MAX_STORES = 5;

string       prog_name [NUM_PROGS];
logic [31:0] prog_code [NUM_PROGS][MAX_INSTR];
int          prog_len  [NUM_PROGS];
logic [63:0] exp_addr  [NUM_PROGS][MAX_STORES];
logic [63:0] exp_data  [NUM_PROGS][MAX_STORES];
int          exp_count [NUM_PROGS];

task automatic add_instr(input int p, input logic [31:0] word);
  prog_code[p][prog_len[p]] = word;
  prog_len[p]++;
endtask

task automatic expect_store(input int p, input int addr, input logic [63:0] data);
  exp_addr[p][exp_count[p]] = 64'(addr);
  exp_data[p][exp_count[p]] = data;
  exp_count[p]++;
endtask

// Data memory starts as word i = 5 * i, registers start at zero
task automatic build_table();
  for (int p = 0; p < NUM_PROGS; p++) begin
    prog_len[p]  = 0;
    exp_count[p] = 0;
  end

  prog_name[0] = "reset_zero_reg";
  add_instr(0, d_format(LDUR_OP, 1, 31, 8));     // X1 = 40
  add_instr(0, r_format(ADD_OP, 31, 1, 1));      // Result discarded
  add_instr(0, d_format(STUR_OP, 31, 31, 28));
  add_instr(0, d_format(STUR_OP, 1, 31, 29));
  add_instr(0, b_format(0));
  expect_store(0, 28, 64'd0);
  expect_store(0, 29, 64'd40);

  prog_name[1] = "alu_forwarding";
  add_instr(1, d_format(LDUR_OP, 1, 31, 7));     // X1 = 35
  add_instr(1, d_format(LDUR_OP, 2, 31, 12));    // X2 = 60
  add_instr(1, r_format(ORR_OP, 9, 31, 31));
  add_instr(1, r_format(ADD_OP, 3, 1, 2));       // 95
  add_instr(1, r_format(SUB_OP, 4, 1, 3));       // -60
  add_instr(1, r_format(AND_OP, 5, 4, 3));       // 0x44
  add_instr(1, r_format(ORR_OP, 6, 5, 1));       // 0x67
  add_instr(1, r_format(ADD_OP, 7, 1, 1));       // 70, older
  add_instr(1, r_format(ADD_OP, 7, 2, 2));       // 120, younger
  add_instr(1, r_format(SUB_OP, 8, 7, 1));       // Must see 120
  add_instr(1, d_format(STUR_OP, 3, 31, 16));
  add_instr(1, d_format(STUR_OP, 4, 31, 17));
  add_instr(1, d_format(STUR_OP, 5, 31, 18));
  add_instr(1, d_format(STUR_OP, 6, 31, 19));
  add_instr(1, d_format(STUR_OP, 8, 31, 20));
  add_instr(1, b_format(0));
  expect_store(1, 16, 64'd95);
  expect_store(1, 17, 64'hFFFF_FFFF_FFFF_FFC4);
  expect_store(1, 18, 64'h44);
  expect_store(1, 19, 64'h67);
  expect_store(1, 20, 64'd85);

  prog_name[2] = "load_use";
  add_instr(2, d_format(LDUR_OP, 2, 31, 4));     // X2 = 20
  add_instr(2, d_format(LDUR_OP, 1, 31, 9));     // X1 = 45
  add_instr(2, r_format(ADD_OP, 3, 1, 2));
  add_instr(2, d_format(STUR_OP, 3, 31, 21));
  add_instr(2, d_format(LDUR_OP, 4, 31, 10));    // X4 = 50
  add_instr(2, d_format(STUR_OP, 4, 31, 22));    // Hazard on Rt
  add_instr(2, b_format(0));
  expect_store(2, 21, 64'd65);
  expect_store(2, 22, 64'd50);

  prog_name[3] = "cbz_both_ways";
  add_instr(3, d_format(LDUR_OP, 1, 31, 3));     // X1 = 15
  add_instr(3, cb_format(5, 4));                 // Taken, X5 is zero
  add_instr(3, d_format(STUR_OP, 1, 31, 24));
  add_instr(3, d_format(STUR_OP, 1, 31, 25));
  add_instr(3, d_format(STUR_OP, 1, 31, 26));
  add_instr(3, cb_format(1, 2));                 // Falls through
  add_instr(3, d_format(STUR_OP, 1, 31, 27));
  add_instr(3, d_format(STUR_OP, 1, 31, 28));
  add_instr(3, b_format(0));
  expect_store(3, 27, 64'd15);
  expect_store(3, 28, 64'd15);

  prog_name[4] = "b_forward";
  add_instr(4, d_format(LDUR_OP, 1, 31, 5));     // X1 = 25
  add_instr(4, d_format(STUR_OP, 1, 31, 16));
  add_instr(4, b_format(3));
  add_instr(4, d_format(STUR_OP, 1, 31, 17));
  add_instr(4, d_format(STUR_OP, 1, 31, 18));
  add_instr(4, d_format(STUR_OP, 1, 31, 19));    // Branch target
  add_instr(4, r_format(ADD_OP, 2, 1, 1));
  add_instr(4, d_format(STUR_OP, 2, 31, 20));
  add_instr(4, b_format(0));
  expect_store(4, 16, 64'd25);
  expect_store(4, 19, 64'd25);
  expect_store(4, 20, 64'd50);
endtask

//--- tb/tb_legv8_core.sv
`timescale 1ns/1ps

module tb_legv8_core;

  // LEGv8 opcode fields
  localparam logic [10:0] ADD_OP  = 11'b10001011000;
  localparam logic [10:0] SUB_OP  = 11'b11001011000;
  localparam logic [10:0] AND_OP  = 11'b10001010000;
  localparam logic [10:0] ORR_OP  = 11'b10101010000;
  localparam logic [10:0] LDUR_OP = 11'b11111000010;
  localparam logic [10:0] STUR_OP = 11'b11111000000;
  localparam logic [7:0]  CBZ_OP  = 8'b10110100;
  localparam logic [5:0]  B_OP    = 6'b000101;

  localparam legv8_pkg::xlen_t START_PC = 64'h0;

  logic                 clk;
  logic                 arst_n_i;
  legv8_pkg::instr_t    instr_i;
  legv8_pkg::xlen_t     pc_o;
  legv8_pkg::dmem_req_t dmem_req_o;
  legv8_pkg::xlen_t     dmem_rdata_i;

  logic [31:0] imem [64];
  logic [63:0] dmem [32];
  logic [63:0] log_addr [$];
  logic [63:0] log_data [$];
  int          err_count;
  int          pass_count;
  int          fail_count;
  string       cur_name;

  function automatic logic [31:0] r_format(input logic [10:0] op, input int rd, input int rn,
                                           input int rm);
    return {op, rm[4:0], 6'b000000, rn[4:0], rd[4:0]};
  endfunction

  function automatic logic [31:0] d_format(input logic [10:0] op, input int rt, input int rn,
                                           input int ofs);
    return {op, ofs[8:0], 2'b00, rn[4:0], rt[4:0]};
  endfunction

  function automatic logic [31:0] cb_format(input int rt, input int ofs);
    return {CBZ_OP, ofs[18:0], rt[4:0]};
  endfunction

  function automatic logic [31:0] b_format(input int ofs);
    return {B_OP, ofs[25:0]};
  endfunction

`include "tb_programs.svh"

  legv8_core #(
    .RESET_PC(START_PC)
  ) legv8_core_inst (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .instr_i     (instr_i),
    .pc_o        (pc_o),
    .dmem_req_o  (dmem_req_o),
    .dmem_rdata_i(dmem_rdata_i)
  );

  always #50 clk = ~clk;

  assign instr_i      = imem[pc_o[7:2]];
  assign dmem_rdata_i = dmem[dmem_req_o.addr[4:0]];

  // Data memory sampled mid-cycle
  always @(negedge clk) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        dmem[i] = 64'(i * 5);
      end
      log_addr.delete();
      log_data.delete();
    end else if (dmem_req_o.wr) begin
      dmem[dmem_req_o.addr[4:0]] = dmem_req_o.wdata;
      log_addr.push_back(dmem_req_o.addr);
      log_data.push_back(dmem_req_o.wdata);
    end
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t ns: %s, %s is %h, expected %h", $time, cur_name, what, actual, expected);
      err_count++;
    end
  endtask

  task automatic run_program(input int p);
    int          i;
    int          n;
    int          seen;
    int          cycles;
    int          errs_before;
    logic [63:0] final_pc;
    cur_name    = prog_name[p];
    errs_before = err_count;
    @(posedge clk);
    #1 arst_n_i = 1'b0;
    for (i = 0; i < 64; i++) begin
      imem[i] = (i < prog_len[p]) ? prog_code[p][i] : 32'h0;  // Zero word decodes as NOP
    end
    repeat (2) @(posedge clk);
    #1 arst_n_i = 1'b1;
    for (i = 0; i < 3; i++) begin
      @(negedge clk);
      check_value(pc_o, START_PC + 64'(i * 4), "pc after reset");
      check_value({62'd0, dmem_req_o.rd, dmem_req_o.wr}, 64'd0, "memory request after reset");
    end
    final_pc = START_PC + 64'((prog_len[p] - 1) * 4);
    seen     = 0;
    cycles   = 0;
    // B #0 resolves in MEM, so its PC comes back every four cycles
    while ((seen < 3) && (cycles < 200)) begin
      @(negedge clk);
      cycles++;
      if (pc_o == final_pc) begin
        seen++;
      end
    end
    if (seen < 3) begin
      $display("Timeout: %s did not settle on its final branch within 200 cycles", cur_name);
      err_count++;
    end else begin
      if (log_addr.size() != exp_count[p]) begin
        $display("Wrong store count in %s: %0d stores seen, %0d expected",
                 cur_name, log_addr.size(), exp_count[p]);
        err_count++;
      end
      n = (log_addr.size() < exp_count[p]) ? log_addr.size() : exp_count[p];
      for (i = 0; i < n; i++) begin
        check_value(log_addr[i], exp_addr[p][i], "store address");
        check_value(log_data[i], exp_data[p][i], "store data");
      end
    end
    if (err_count == errs_before) begin
      pass_count++;
      $display("PASS %s", cur_name);
    end else begin
      fail_count++;
      $display("FAIL %s", cur_name);
    end
  endtask

  initial begin
    clk        = 1'b0;
    arst_n_i   = 1'b0;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    cur_name   = "";
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'h0;
    end
    for (int i = 0; i < 32; i++) begin
      dmem[i] = 64'(i * 5);
    end
    build_table();
    for (int p = 0; p < NUM_PROGS; p++) begin
      run_program(p);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             NUM_PROGS, pass_count, fail_count, err_count);
    if ((fail_count == 0) && (err_count == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/legv8_core.sv
`timescale 1ns/1ps

module legv8_core #(
  parameter legv8_pkg::xlen_t RESET_PC = '0
) (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  legv8_pkg::instr_t    instr_i,
  output legv8_pkg::xlen_t     pc_o,
  output legv8_pkg::dmem_req_t dmem_req_o,
  input  legv8_pkg::xlen_t     dmem_rdata_i
);

  legv8_pkg::if_id_t  if_id;
  legv8_pkg::id_ex_t  id_ex;
  legv8_pkg::ex_mem_t ex_mem;
  legv8_pkg::wb_t     wb;
  logic               stall;
  logic               branch_taken;
  legv8_pkg::xlen_t   branch_target;
  legv8_pkg::xlen_t   mem_fwd;

  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) fetch_stage_inst (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .instr_i        (instr_i),
    .stall_i        (stall),
    .branch_taken_i (branch_taken),
    .branch_target_i(branch_target),
    .pc_o           (pc_o),
    .if_id_o        (if_id)
  );

  decode_stage decode_stage_inst (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .if_id_i       (if_id),
    .wb_i          (wb),
    .branch_taken_i(branch_taken),
    .stall_o       (stall),
    .id_ex_o       (id_ex)
  );

  execute_stage execute_stage_inst (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .id_ex_i       (id_ex),
    .mem_fwd_i     (mem_fwd),
    .mem_rd_i      (ex_mem.rd),
    .mem_reg_wr_i  (ex_mem.ctrl.reg_wr),
    .wb_i          (wb),
    .branch_taken_i(branch_taken),
    .ex_mem_o      (ex_mem)
  );

  mem_wb_stage mem_wb_stage_inst (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .ex_mem_i       (ex_mem),
    .dmem_rdata_i   (dmem_rdata_i),
    .dmem_req_o     (dmem_req_o),
    .branch_taken_o (branch_taken),
    .branch_target_o(branch_target),
    .mem_fwd_o      (mem_fwd),
    .wb_o           (wb)
  );

endmodule

//--- hdl/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  legv8_pkg::ex_mem_t   ex_mem_i,
  input  legv8_pkg::xlen_t     dmem_rdata_i,
  output legv8_pkg::dmem_req_t dmem_req_o,
  output logic                 branch_taken_o,
  output legv8_pkg::xlen_t     branch_target_o,
  output legv8_pkg::xlen_t     mem_fwd_o,
  output legv8_pkg::wb_t       wb_o
);

  legv8_pkg::mem_wb_t mem_wb;

  assign branch_taken_o  = ex_mem_i.ctrl.is_b
                           || (ex_mem_i.ctrl.is_cbz && ex_mem_i.alu_zero);
  assign branch_target_o = ex_mem_i.branch_target;
  assign mem_fwd_o       = ex_mem_i.alu_result;

  assign dmem_req_o.addr  = ex_mem_i.alu_result;
  assign dmem_req_o.wdata = ex_mem_i.store_data;
  assign dmem_req_o.rd    = ex_mem_i.ctrl.mem_rd;
  assign dmem_req_o.wr    = ex_mem_i.ctrl.mem_wr;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mem_wb <= '0;
    end else begin
      mem_wb.reg_wr     <= ex_mem_i.ctrl.reg_wr;
      mem_wb.mem_to_reg <= ex_mem_i.ctrl.mem_to_reg;
      mem_wb.alu_result <= ex_mem_i.alu_result;
      mem_wb.load_data  <= dmem_rdata_i;
      mem_wb.rd         <= ex_mem_i.rd;
    end
  end

  // Write-back select
  assign wb_o.en   = mem_wb.reg_wr;
  assign wb_o.rd   = mem_wb.rd;
  assign wb_o.data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                clk,
  input  logic                arst_n_i,
  input  legv8_pkg::id_ex_t   id_ex_i,
  input  legv8_pkg::xlen_t    mem_fwd_i,
  input  legv8_pkg::reg_idx_t mem_rd_i,
  input  logic                mem_reg_wr_i,
  input  legv8_pkg::wb_t      wb_i,
  input  logic                branch_taken_i,
  output legv8_pkg::ex_mem_t  ex_mem_o
);

  legv8_pkg::fwd_sel_e sel_a;
  legv8_pkg::fwd_sel_e sel_b;
  legv8_pkg::xlen_t    op_a;
  legv8_pkg::xlen_t    op_b;
  legv8_pkg::xlen_t    alu_b;
  legv8_pkg::xlen_t    alu_result;
  logic                alu_zero;
  legv8_pkg::xlen_t    branch_target;

  // Younger result in EX/MEM takes priority over WB
  function automatic legv8_pkg::fwd_sel_e fwd_pick(input legv8_pkg::reg_idx_t idx);
    if (mem_reg_wr_i && (mem_rd_i != legv8_pkg::ZERO_REG) && (mem_rd_i == idx)) begin
      return legv8_pkg::FROM_MEM;
    end
    if (wb_i.en && (wb_i.rd != legv8_pkg::ZERO_REG) && (wb_i.rd == idx)) begin
      return legv8_pkg::FROM_WB;
    end
    return legv8_pkg::REGFILE;
  endfunction

  function automatic legv8_pkg::xlen_t fwd_mux(input legv8_pkg::fwd_sel_e sel,
                                               input legv8_pkg::xlen_t rf_data);
    case (sel)
      legv8_pkg::FROM_MEM: return mem_fwd_i;
      legv8_pkg::FROM_WB:  return wb_i.data;
      default:             return rf_data;
    endcase
  endfunction

  always_comb begin
    sel_a = fwd_pick(id_ex_i.rn);
    sel_b = fwd_pick(id_ex_i.rm);
    op_a  = fwd_mux(sel_a, id_ex_i.rs1_data);
    op_b  = fwd_mux(sel_b, id_ex_i.rs2_data);
  end

  assign alu_b = id_ex_i.ctrl.alu_src ? id_ex_i.imm : op_b;

  always_comb begin
    case (id_ex_i.ctrl.alu_ctl)
      legv8_pkg::ALU_AND:    alu_result = op_a & alu_b;
      legv8_pkg::ALU_ORR:    alu_result = op_a | alu_b;
      legv8_pkg::ALU_ADD:    alu_result = op_a + alu_b;
      legv8_pkg::ALU_SUB:    alu_result = op_a - alu_b;
      legv8_pkg::ALU_PASS_B: alu_result = alu_b;
      default:               alu_result = '0;
    endcase
  end

  assign alu_zero      = (alu_result == '0);
  assign branch_target = id_ex_i.pc + (id_ex_i.imm << 2);  // Word offset

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_mem_o <= '0;
    end else begin
      if (branch_taken_i) begin
        ex_mem_o.ctrl <= '0;
      end else begin
        ex_mem_o.ctrl <= id_ex_i.ctrl;
      end
      ex_mem_o.branch_target <= branch_target;
      ex_mem_o.alu_zero      <= alu_zero;
      ex_mem_o.alu_result    <= alu_result;
      ex_mem_o.store_data    <= op_b;     // Forwarded Rt
      ex_mem_o.rd            <= id_ex_i.rd;
    end
  end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic              clk,
  input  logic              arst_n_i,
  input  legv8_pkg::if_id_t if_id_i,
  input  legv8_pkg::wb_t    wb_i,
  input  logic              branch_taken_i,
  output logic              stall_o,
  output legv8_pkg::id_ex_t id_ex_o
);

  legv8_pkg::instr_t   instr;
  logic [10:0]         opcode;
  logic                is_b_op;
  logic                is_cbz_op;
  logic                uses_rt;
  legv8_pkg::ctrl_t    ctrl;
  legv8_pkg::reg_idx_t rn;
  legv8_pkg::reg_idx_t rm_sel;
  legv8_pkg::reg_idx_t rd;
  legv8_pkg::xlen_t    imm;
  legv8_pkg::xlen_t    rs1_data;
  legv8_pkg::xlen_t    rs2_data;

  assign instr     = if_id_i.instr;
  assign opcode    = instr[31:21];
  assign is_b_op   = (instr[31:26] == legv8_pkg::OP_B);
  assign is_cbz_op = (instr[31:24] == legv8_pkg::OP_CBZ);
  assign rn        = instr[9:5];
  assign rd        = instr[4:0];
  assign rm_sel    = uses_rt ? instr[4:0] : instr[20:16];

  always_comb begin
    ctrl    = '0;
    uses_rt = 1'b0;
    if (is_b_op) begin
      ctrl.is_b    = 1'b1;
      ctrl.alu_ctl = legv8_pkg::ALU_PASS_B;
    end else if (is_cbz_op) begin
      ctrl.is_cbz  = 1'b1;
      ctrl.alu_ctl = legv8_pkg::ALU_PASS_B;  // Zero flag tests Rt
      uses_rt      = 1'b1;
    end else begin
      case (opcode)
        legv8_pkg::OP_LDUR: begin
          ctrl.alu_src    = 1'b1;
          ctrl.alu_ctl    = legv8_pkg::ALU_ADD;
          ctrl.mem_rd     = 1'b1;
          ctrl.reg_wr     = 1'b1;
          ctrl.mem_to_reg = 1'b1;
        end
        legv8_pkg::OP_STUR: begin
          ctrl.alu_src = 1'b1;
          ctrl.alu_ctl = legv8_pkg::ALU_ADD;
          ctrl.mem_wr  = 1'b1;
          uses_rt      = 1'b1;
        end
        legv8_pkg::OP_ADD: begin
          ctrl.alu_ctl = legv8_pkg::ALU_ADD;
          ctrl.reg_wr  = 1'b1;
        end
        legv8_pkg::OP_SUB: begin
          ctrl.alu_ctl = legv8_pkg::ALU_SUB;
          ctrl.reg_wr  = 1'b1;
        end
        legv8_pkg::OP_AND: begin
          ctrl.alu_ctl = legv8_pkg::ALU_AND;
          ctrl.reg_wr  = 1'b1;
        end
        legv8_pkg::OP_ORR: begin
          ctrl.alu_ctl = legv8_pkg::ALU_ORR;
          ctrl.reg_wr  = 1'b1;
        end
        default: begin
          ctrl = '0;                          // Unknown opcode runs as NOP
        end
      endcase
    end
    if (!if_id_i.valid) begin
      ctrl = '0;
    end
  end

  always_comb begin
    if (is_b_op) begin
      imm = {{38{instr[25]}}, instr[25:0]};
    end else if (is_cbz_op) begin
      imm = {{45{instr[23]}}, instr[23:5]};
    end else begin
      imm = {{55{instr[20]}}, instr[20:12]};  // Load/store offset
    end
  end

  // Load in EX feeding this instruction
  assign stall_o = if_id_i.valid && id_ex_o.ctrl.mem_rd
                   && (id_ex_o.rd != legv8_pkg::ZERO_REG)
                   && ((id_ex_o.rd == rn) || (id_ex_o.rd == rm_sel));

  reg_file reg_file_inst (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .rd_idx1_i (rn),
    .rd_idx2_i (rm_sel),
    .wb_i      (wb_i),
    .rd_data1_o(rs1_data),
    .rd_data2_o(rs2_data)
  );

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_ex_o <= '0;
    end else begin
      if (branch_taken_i || stall_o) begin
        id_ex_o.ctrl <= '0;   // Bubble
      end else begin
        id_ex_o.ctrl <= ctrl;
      end
      id_ex_o.pc       <= if_id_i.pc;
      id_ex_o.rs1_data <= rs1_data;
      id_ex_o.rs2_data <= rs2_data;
      id_ex_o.imm      <= imm;
      id_ex_o.rn       <= rn;
      id_ex_o.rm       <= rm_sel;
      id_ex_o.rd       <= rd;
    end
  end

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter legv8_pkg::xlen_t RESET_PC = '0
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  legv8_pkg::instr_t instr_i,
  input  logic              stall_i,
  input  logic              branch_taken_i,
  input  legv8_pkg::xlen_t  branch_target_i,
  output legv8_pkg::xlen_t  pc_o,
  output legv8_pkg::if_id_t if_id_o
);

  legv8_pkg::xlen_t pc_next;

  always_comb begin
    if (branch_taken_i) begin
      pc_next = branch_target_i;  // Squash beats stall
    end else if (stall_i) begin
      pc_next = pc_o;
    end else begin
      pc_next = pc_o + 64'd4;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_o <= RESET_PC;
    end else begin
      pc_o <= pc_next;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      if_id_o <= '0;
    end else if (branch_taken_i) begin
      if_id_o.valid <= 1'b0;      // Drop the wrong-path fetch
    end else if (!stall_i) begin
      if_id_o.valid <= 1'b1;
      if_id_o.pc    <= pc_o;
      if_id_o.instr <= instr_i;
    end
  end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                clk,
  input  logic                arst_n_i,
  input  legv8_pkg::reg_idx_t rd_idx1_i,
  input  legv8_pkg::reg_idx_t rd_idx2_i,
  input  legv8_pkg::wb_t      wb_i,
  output legv8_pkg::xlen_t    rd_data1_o,
  output legv8_pkg::xlen_t    rd_data2_o
);

  legv8_pkg::xlen_t regs [31];  // X0 to X30

  function automatic legv8_pkg::xlen_t read_port(input legv8_pkg::reg_idx_t idx);
    if (idx == legv8_pkg::ZERO_REG) begin
      return '0;
    end
    if (wb_i.en && (wb_i.rd == idx)) begin
      return wb_i.data;         // Same-cycle write passes through
    end
    return regs[idx];
  endfunction

  always_comb begin
    rd_data1_o = read_port(rd_idx1_i);
    rd_data2_o = read_port(rd_idx2_i);
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 31; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.en && (wb_i.rd != legv8_pkg::ZERO_REG)) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

endmodule

//--- hdl/legv8_pkg.sv
package legv8_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;

  localparam reg_idx_t ZERO_REG = 5'd31;

  typedef enum logic [3:0] {
    ALU_AND    = 4'b0000,
    ALU_ORR    = 4'b0001,
    ALU_ADD    = 4'b0010,
    ALU_SUB    = 4'b0110,
    ALU_PASS_B = 4'b0111
  } alu_ctl_e;

  // Eleven-bit opcodes live in instr[31:21]
  localparam logic [10:0] OP_ADD  = 11'b10001011000;
  localparam logic [10:0] OP_SUB  = 11'b11001011000;
  localparam logic [10:0] OP_AND  = 11'b10001010000;
  localparam logic [10:0] OP_ORR  = 11'b10101010000;
  localparam logic [10:0] OP_LDUR = 11'b11111000010;
  localparam logic [10:0] OP_STUR = 11'b11111000000;
  localparam logic [7:0]  OP_CBZ  = 8'b10110100;  // instr[31:24]
  localparam logic [5:0]  OP_B    = 6'b000101;    // instr[31:26]

  typedef struct packed {
    logic     alu_src;     // Immediate as operand B
    alu_ctl_e alu_ctl;
    logic     mem_rd;
    logic     mem_wr;
    logic     reg_wr;
    logic     mem_to_reg;
    logic     is_cbz;
    logic     is_b;
  } ctrl_t;

  typedef struct packed {
    logic   valid;
    xlen_t  pc;
    instr_t instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    xlen_t    pc;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm;
    reg_idx_t rn;
    reg_idx_t rm;          // Second read register, Rt for STUR and CBZ
    reg_idx_t rd;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    xlen_t    branch_target;
    logic     alu_zero;
    xlen_t    alu_result;
    xlen_t    store_data;
    reg_idx_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic     reg_wr;
    logic     mem_to_reg;
    xlen_t    alu_result;
    xlen_t    load_data;
    reg_idx_t rd;
  } mem_wb_t;

  typedef struct packed {
    logic     en;
    reg_idx_t rd;
    xlen_t    data;
  } wb_t;

  typedef struct packed {
    xlen_t addr;
    xlen_t wdata;
    logic  rd;
    logic  wr;
  } dmem_req_t;

  typedef enum logic [1:0] {
    REGFILE,
    FROM_MEM,
    FROM_WB
  } fwd_sel_e;

endpackage
